// ==== dv/tile_display_tb.sv ====
`timescale 1ns/10ps
// testbench for tile_display, runs two frames and checks every output position
// tables are filled from xorshift data seeded with 22, then row 1 and the bg are changed
// checks sample at the falling edge, one clock after the counters show a position
module tile_display_tb import video_pkg::*, tile_pkg::*; ();

	typedef enum {SYNC, BLANK, BACKGROUND, MAP} check_kind_e;

	localparam int CLK_PERIOD = 8;
	localparam int FRAME_CLOCKS = H_TOTAL * V_TOTAL;
	localparam int FRAMES_RUN = 2;
	localparam int WATCHDOG_CLOCKS = H_TOTAL * (FRAMES_RUN * V_TOTAL + 20) + 2000;
	localparam int MAX_CHECKS = 16;

	logic       clk;
	logic       reset;
	logic       chipselect;
	logic       write;
	reg_addr_e  address;
	logic [7:0] writedata;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic       vga_clk;
	logic       vga_hs;
	logic       vga_vs;
	logic       vga_blank_n;

	string       check_name [MAX_CHECKS];
	check_kind_e check_kind [MAX_CHECKS];
	int          check_frame [MAX_CHECKS];
	int          check_v_lo [MAX_CHECKS];
	int          check_v_hi [MAX_CHECKS];
	int          check_h_lo [MAX_CHECKS];
	int          check_h_hi [MAX_CHECKS];
	int          check_errors [MAX_CHECKS];
	int          check_count [MAX_CHECKS];
	bit          check_done [MAX_CHECKS];
	int          num_checks;

	logic [7:0]  name_model [NAME_DEPTH];	// what the host has written so far
	logic [7:0]  pattern_model [PATTERN_DEPTH];
	logic [23:0] bg_model;
	bit          code_seen [16];
	logic [31:0] rng;
	int          cnt;	// position the DUT counters show now
	int          passed_tests;
	int          failed_tests;
	int          total_errors;

	tile_display dut (.clk, .reset, .chipselect, .write, .address, .writedata,
		.vga_r, .vga_g, .vga_b, .vga_clk, .vga_hs, .vga_vs, .vga_blank_n);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (!reset) cnt <= cnt + 1;
	end

	always @(negedge clk) begin
		if (!reset && cnt >= 1) check_position(cnt - 1);	// outputs lag by one clock
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [23:0] code_to_rgb(input logic [3:0] code);
		case (code)
			4'd1: return 24'hfef104;
			4'd2: return 24'hfe0e03;
			4'd3: return 24'hfeb846;
			4'd4: return 24'h00ecfe;
			4'd5: return 24'hfdbff9;
			4'd6: return 24'he5dfee;
			4'd7: return 24'h1e26b8;
			4'd8: return 24'hffc0b7;
			default: return 24'hffffff;	// 9 and 10..15 are white
		endcase
	endfunction

	// colour code of display position (h,v) inside the map window
	function automatic logic [3:0] map_code(input int h, input int v);
		int         trow;
		int         prow;
		int         col;
		int         pix;
		logic [7:0] nbyte;
		logic [7:0] pbyte;
		trow = (v - 8) / 8;
		prow = (v - 8) % 8;
		col = h / 16;
		pix = (h / 2) % 8;
		nbyte = name_model[trow * 32 + col];
		pbyte = pattern_model[int'(nbyte[2:0]) * 32 + prow * 4 + pix / 2];
		return (pix % 2 == 0) ? pbyte[7:4] : pbyte[3:0];	// left pixel in high nibble
	endfunction

	task automatic add_check(input string name, input check_kind_e kind, input int frame,
		input int v_lo, input int v_hi, input int h_lo, input int h_hi);
		check_name[num_checks] = name;
		check_kind[num_checks] = kind;
		check_frame[num_checks] = frame;
		check_v_lo[num_checks] = v_lo;
		check_v_hi[num_checks] = v_hi;
		check_h_lo[num_checks] = h_lo;
		check_h_hi[num_checks] = h_hi;
		num_checks++;
	endtask

	task automatic note_mismatch(input int i, input string field, input logic [23:0] exp,
		input logic [23:0] act, input int h, input int v);
		check_errors[i]++;
		total_errors++;
		if (check_errors[i] <= 4) begin	// keep the log short on a broken test
			$display("MISMATCH %s %s at h=%0d v=%0d: expected %h, actual %h",
				check_name[i], field, h, v, exp, act);
		end
	endtask

	task automatic report_check(input int i);
		check_done[i] = 1'b1;
		if (check_errors[i] == 0) begin
			passed_tests++;
			$display("PASS %s: %0d positions", check_name[i], check_count[i]);
		end else begin
			failed_tests++;
			$display("FAIL %s: %0d mismatches in %0d positions", check_name[i],
				check_errors[i], check_count[i]);
		end
	endtask

	task automatic check_position(input int p);
		int          h;
		int          v;
		int          frame;
		int          i;
		logic        exp_hs;
		logic        exp_vs;
		logic        exp_blank;
		logic [3:0]  code;
		logic [23:0] exp_rgb;
		logic [23:0] act_rgb;
		h = p % H_TOTAL;
		v = (p / H_TOTAL) % V_TOTAL;
		frame = p / FRAME_CLOCKS + 1;	// frames counted from 1
		exp_hs = !(h >= 1312 && h <= 1503);
		exp_vs = !(v >= 490 && v <= 491);
		exp_blank = (h < 1280) && (v < 480);
		act_rgb = {vga_r, vga_g, vga_b};
		if (!exp_blank) begin
			exp_rgb = 24'h0;
		end else if (v >= 8 && v <= 71 && h < 512) begin
			code = map_code(h, v);
			code_seen[code] = 1'b1;
			exp_rgb = (code == 4'd0) ? bg_model : code_to_rgb(code);
		end else begin
			exp_rgb = bg_model;
		end
		for (i = 0; i < num_checks; i++) begin
			if (frame == check_frame[i] && v >= check_v_lo[i] && v <= check_v_hi[i]
				&& h >= check_h_lo[i] && h <= check_h_hi[i]) begin
				check_count[i]++;
				case (check_kind[i])
					SYNC: begin
						if (vga_hs !== exp_hs) note_mismatch(i, "vga_hs", exp_hs, vga_hs, h, v);
						if (vga_vs !== exp_vs) note_mismatch(i, "vga_vs", exp_vs, vga_vs, h, v);
						if (vga_clk !== h[0]) note_mismatch(i, "vga_clk", h[0], vga_clk, h, v);
					end
					BLANK: begin
						if (vga_blank_n !== exp_blank)
							note_mismatch(i, "vga_blank_n", exp_blank, vga_blank_n, h, v);
						if (!exp_blank && act_rgb !== 24'h0)
							note_mismatch(i, "rgb", 24'h0, act_rgb, h, v);
					end
					default: begin
						if (act_rgb !== exp_rgb) note_mismatch(i, "rgb", exp_rgb, act_rgb, h, v);
					end
				endcase
				if (v == check_v_hi[i] && h == check_h_hi[i]) report_check(i);
			end
		end
	endtask

	task automatic host_write(input reg_addr_e addr, input logic [7:0] data);
		@(negedge clk);
		chipselect = 1'b1;
		write = 1'b1;
		address = addr;
		writedata = data;
	endtask

	task automatic bus_release();
		@(negedge clk);
		chipselect = 1'b0;
		write = 1'b0;
	endtask

	task automatic wait_until(input int target);
		while (cnt < target) @(negedge clk);
	endtask

	task automatic load_tables();
		int k;
		host_write(REG_POINTER, 8'd0);
		for (k = 0; k < NAME_DEPTH; k++) begin
			rng = xorshift32(rng);
			name_model[k] = rng[7:0];
			host_write(REG_NAME_DATA, rng[7:0]);
		end
		host_write(REG_POINTER, 8'd0);	// pointer has wrapped already, set it anyway
		for (k = 0; k < PATTERN_DEPTH; k++) begin
			rng = xorshift32(rng);
			pattern_model[k] = rng[7:0];
			host_write(REG_PATTERN_DATA, rng[7:0]);
		end
		bus_release();
	endtask

	initial begin
		reset = 1'b1;
		chipselect = 1'b0;
		write = 1'b0;
		address = REG_POINTER;
		writedata = 8'h00;
		rng = 32'd22;
		bg_model = 24'h000020;	// reset value of the bg registers
		cnt = 0;
		num_checks = 0;
		add_check("sync_frame1", SYNC, 1, 0, 524, 0, 1599);
		add_check("blank_frame1", BLANK, 1, 0, 524, 0, 1599);
		add_check("bg_top", BACKGROUND, 1, 0, 7, 0, 1279);
		add_check("bg_right", BACKGROUND, 1, 8, 71, 512, 1279);
		add_check("bg_bottom", BACKGROUND, 1, 72, 479, 0, 1279);
		add_check("map_frame1", MAP, 1, 8, 71, 0, 511);
		add_check("new_bg_top", BACKGROUND, 2, 0, 7, 0, 1279);
		add_check("new_bg_side", BACKGROUND, 2, 8, 15, 512, 1279);
		add_check("new_names", MAP, 2, 16, 23, 128, 159);	// tile row 1, columns 8 and 9
		add_check("map_frame2", MAP, 2, 8, 71, 0, 511);
		add_check("sync_frame2", SYNC, 2, 0, 524, 0, 1599);
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (vga_hs === 1'b1 && vga_vs === 1'b1 && vga_blank_n === 1'b0
			&& {vga_r, vga_g, vga_b} === 24'h0) begin
			passed_tests++;
			$display("PASS reset_state");
		end else begin
			failed_tests++;
			$display("FAIL reset_state: syncs not high, blank_n not low or rgb not zero");
		end
		reset = 1'b0;
		load_tables();
		wait_until(H_ACTIVE + 16);	// bg changes inside the line 0 retrace
		host_write(REG_BG_RED, 8'h18);
		host_write(REG_BG_GREEN, 8'h60);
		host_write(REG_BG_BLUE, 8'h30);
		bg_model = 24'h186030;
		bus_release();
		wait_until(485 * H_TOTAL);	// vertical blank of frame 1
		host_write(REG_POINTER, 8'd40);	// row 1, column 8
		host_write(REG_NAME_DATA, name_model[40] ^ 8'h03);
		host_write(REG_NAME_DATA, name_model[41] ^ 8'h05);	// lands at 41 by auto increment
		name_model[40] = name_model[40] ^ 8'h03;
		name_model[41] = name_model[41] ^ 8'h05;
		host_write(REG_BG_BLUE, 8'hc8);
		bg_model[7:0] = 8'hc8;
		bus_release();
		wait_until(FRAMES_RUN * FRAME_CLOCKS + 2);
		for (int i = 0; i < num_checks; i++) begin
			if (!check_done[i]) begin
				failed_tests++;
				$display("test %s never reached the end of its range", check_name[i]);
			end
		end
		for (int c = 0; c < 16; c++) begin
			if (!code_seen[c]) begin
				failed_tests++;
				$display("colour code %0d never appeared on the map", c);
			end
		end
		$display("tests passed %0d, failed %0d, mismatches %0d", passed_tests, failed_tests,
			total_errors);
		if (failed_tests == 0 && total_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CLOCKS * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d clocks", WATCHDOG_CLOCKS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== source/color_out.sv ====
`timescale 1ns/10ps
// output register stage, every output lags the counters by one clock
// code 0 shows the background colour, blanked pixels are black
module color_out import video_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  color_code_t color_code,
	input  rgb_t        bg_color,
	input  logic        hs_raw,
	input  logic        vs_raw,
	input  logic        blank_raw,
	input  logic        hcount_lsb,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b,
	output logic        vga_clk,
	output logic        vga_hs,
	output logic        vga_vs,
	output logic        vga_blank_n
);

	rgb_t pixel;

	always_comb begin
		if (!blank_raw) pixel = '0;	// black outside the visible area
		else if (color_code == '0) pixel = bg_color;
		else pixel = COLOR_TABLE[color_code];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			{vga_r, vga_g, vga_b} <= '0;
			vga_clk <= 1'b0;
			vga_hs <= 1'b1;	// syncs idle high
			vga_vs <= 1'b1;
			vga_blank_n <= 1'b0;
		end else begin
			{vga_r, vga_g, vga_b} <= pixel;
			vga_clk <= hcount_lsb;	// 25 MHz pixel clock, aligned with the data
			vga_hs <= hs_raw;
			vga_vs <= vs_raw;
			vga_blank_n <= blank_raw;
		end
	end

endmodule

// ==== source/host_regs.sv ====
`timescale 1ns/10ps
// host registers, one write per clock and no acknowledge
// data writes land in the table at the pointer, which then advances and wraps at 255
module host_regs import video_pkg::*, tile_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       chipselect,
	input  logic       write,
	input  reg_addr_e  address,
	input  logic [7:0] writedata,
	output logic       name_we,
	output logic       pattern_we,
	output vram_addr_t wr_addr,
	output logic [7:0] wr_data,
	output rgb_t       bg_color
);

	logic       wr_en;
	vram_addr_t pointer;	// next table index to write
	logic [7:0] bg_red;
	logic [7:0] bg_green;
	logic [7:0] bg_blue;

	assign wr_en = chipselect && write;
	assign name_we = wr_en && (address == REG_NAME_DATA);	// table write in the same clock
	assign pattern_we = wr_en && (address == REG_PATTERN_DATA);
	assign wr_addr = pointer;
	assign wr_data = writedata;
	assign bg_color = {bg_red, bg_green, bg_blue};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pointer <= '0;
			bg_red <= 8'h00;
			bg_green <= 8'h00;
			bg_blue <= 8'h20;	// dark blue background out of reset
		end else if (wr_en) begin
			case (address)
				REG_POINTER: pointer <= writedata;
				REG_NAME_DATA, REG_PATTERN_DATA: pointer <= pointer + 8'd1;	// auto increment
				REG_BG_RED: bg_red <= writedata;
				REG_BG_GREEN: bg_green <= writedata;
				REG_BG_BLUE: bg_blue <= writedata;
				default: ;	// unmapped addresses are ignored
			endcase
		end
	end

endmodule

// ==== source/line_shifter.sv ====
`timescale 1ns/10ps
// line buffer of 128 bytes, 256 colour codes for one map line
// write pointer restarts at every line end, so a fetch must deliver exactly 128 bytes
module line_shifter import video_pkg::*, tile_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  hcount_t     hcount,
	input  logic        load,
	input  logic [7:0]  load_data,
	input  logic        line_valid,
	output color_code_t color_code
);

	logic [7:0] line_buf [MAP_COLS * BYTES_PER_TILE_ROW];
	logic [6:0] wr_ptr;
	logic [7:0] nib_idx;	// map pixel index, equals hcount/2 in the map window
	logic [7:0] cur_byte;
	logic       map_window;

	assign map_window = hcount < MAP_COLS * TILE_SIZE * 2;	// hcount 0 to 511

	always_ff @(posedge clk) begin
		if (load) line_buf[wr_ptr] <= load_data;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			nib_idx <= '0;
		end else if (hcount == H_TOTAL - 1) begin
			wr_ptr <= '0;
			nib_idx <= '0;
		end else begin
			if (load) wr_ptr <= wr_ptr + 7'd1;
			if (map_window && hcount[0]) nib_idx <= nib_idx + 8'd1;	// steps as hcount turns even
		end
	end

	assign cur_byte = line_buf[nib_idx[7:1]];
	// left pixel sits in the high nibble
	assign color_code = (line_valid && map_window)
		? (nib_idx[0] ? cur_byte[3:0] : cur_byte[7:4]) : '0;

endmodule

// ==== source/tile_display.sv ====
`timescale 1ns/10ps
// tile map generator for 640x480 VGA from a 50 MHz clock
// host sets the pointer, then streams name or pattern bytes; map shows on lines 8 to 71
// outputs for counter position (h,v) appear one clock after the counters show it
module tile_display import video_pkg::*, tile_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       chipselect,
	input  logic       write,
	input  reg_addr_e  address,
	input  logic [7:0] writedata,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic       vga_clk,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       vga_blank_n
);

	hcount_t     hcount;
	vcount_t     vcount;
	logic        hs_raw;
	logic        vs_raw;
	logic        blank_raw;
	logic        name_we;
	logic        pattern_we;
	vram_addr_t  wr_addr;
	logic [7:0]  wr_data;
	rgb_t        bg_color;
	vram_addr_t  name_ra;
	vram_addr_t  pattern_ra;
	logic [7:0]  name_dout;
	logic [7:0]  pattern_dout;
	logic        load;
	logic [7:0]  load_data;
	logic        line_valid;
	color_code_t color_code;

	vga_timing timing (.clk, .reset, .hcount, .vcount, .hs_raw, .vs_raw, .blank_raw);

	host_regs regs (.clk, .reset, .chipselect, .write, .address, .writedata,
		.name_we, .pattern_we, .wr_addr, .wr_data, .bg_color);

	video_ram #(.DEPTH(NAME_DEPTH)) name_ram (.clk, .we(name_we), .wa(wr_addr),
		.ra(name_ra), .din(wr_data), .dout(name_dout));

	video_ram #(.DEPTH(PATTERN_DEPTH)) pattern_ram (.clk, .we(pattern_we), .wa(wr_addr),
		.ra(pattern_ra), .din(wr_data), .dout(pattern_dout));

	tile_fetch fetch (.clk, .reset, .hcount, .vcount, .name_ra, .pattern_ra,
		.name_dout, .pattern_dout, .load, .load_data, .line_valid);

	line_shifter shifter (.clk, .reset, .hcount, .load, .load_data, .line_valid,
		.color_code);

	color_out out_stage (.clk, .reset, .color_code, .bg_color, .hs_raw, .vs_raw,
		.blank_raw, .hcount_lsb(hcount[0]), .vga_r, .vga_g, .vga_b, .vga_clk,
		.vga_hs, .vga_vs, .vga_blank_n);

endmodule

// ==== source/tile_fetch.sv ====
`timescale 1ns/10ps
// fills the line buffer for line v+1 during the horizontal retrace of line v
// name reads for the next tile overlap the pattern loads of the current one
// 196 clocks from FETCH_START, 32 tiles of 4 bytes, left to right
module tile_fetch import video_pkg::*, tile_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  hcount_t    hcount,
	input  vcount_t    vcount,
	output vram_addr_t name_ra,
	output vram_addr_t pattern_ra,
	input  logic [7:0] name_dout,
	input  logic [7:0] pattern_dout,
	output logic       load,
	output logic [7:0] load_data,
	output logic       line_valid
);

	fetch_state_e state;
	logic [5:0]   map_line;	// map pixel row, tile row in [5:3], pixel row in [2:0]
	logic [4:0]   tile;	// tile column being loaded
	logic [1:0]   byte_cnt;	// byte within the tile row
	vcount_t      next_v;
	logic         start;
	vram_addr_t   pattern_base;

	assign next_v = vcount + 10'd1;
	assign start = (hcount == FETCH_START) && (next_v >= V_START)
		&& (next_v < V_START + MAP_ROWS * TILE_SIZE);
	// pattern number x 32 + pixel row x 4
	assign pattern_base = {name_dout[$clog2(PATTERN_COUNT)-1:0], map_line[2:0], 2'b00};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			line_valid <= 1'b0;
			map_line <= '0;
			tile <= '0;
			byte_cnt <= '0;
			name_ra <= '0;
			pattern_ra <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						map_line <= 6'(next_v - V_START);
						state <= READ_NAME;
					end else if (hcount == H_TOTAL - 1) begin
						line_valid <= 1'b0;	// nothing fetched, next line shows background
					end
				end
				READ_NAME: begin
					name_ra <= {map_line[5:3], 5'd0};	// first tile of the tile row
					tile <= '0;
					state <= WAIT_NAME;
				end
				WAIT_NAME: state <= READ_PATTERN;	// ram samples the name address
				READ_PATTERN: begin
					pattern_ra <= pattern_base;
					name_ra <= name_ra + 8'd1;	// prefetch the next tile's name
					state <= WAIT_PATTERN;
				end
				WAIT_PATTERN: begin
					pattern_ra <= pattern_ra + 8'd1;	// stream the row, one byte per clock
					byte_cnt <= '0;
					state <= LOAD_BYTE;
				end
				LOAD_BYTE: begin
					pattern_ra <= pattern_ra + 8'd1;
					byte_cnt <= byte_cnt + 2'd1;
					if (byte_cnt == BYTES_PER_TILE_ROW - 1) state <= NEXT_TILE;
				end
				NEXT_TILE: begin
					pattern_ra <= pattern_base;	// name_dout already holds the next tile
					name_ra <= name_ra + 8'd1;
					tile <= tile + 5'd1;
					if (tile == MAP_COLS - 1) begin
						line_valid <= 1'b1;
						state <= LINE_READY;
					end else begin
						state <= WAIT_PATTERN;
					end
				end
				LINE_READY: begin
					if (hcount == H_TOTAL - 1) state <= IDLE;	// line_valid holds for line v+1
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign load = state == LOAD_BYTE;
	assign load_data = pattern_dout;

	// a fetch still running at the wrap would leave line v+1 half loaded
	assert property (@(posedge clk) disable iff (reset)
		!(state inside {IDLE, LINE_READY}) |-> hcount != H_TOTAL - 1);
	// loads stay in the retrace so the buffer never changes under the visible map
	assert property (@(posedge clk) disable iff (reset)
		load |-> hcount > FETCH_START);

endmodule

// ==== source/tile_pkg.sv ====
// tile map of 32x8 tiles, each 8x8 pixels of 4-bit codes, from eight patterns
// name byte low 3 bits pick the pattern, pattern bytes hold two pixels high nibble first
package tile_pkg;

	localparam int MAP_COLS = 32;
	localparam int MAP_ROWS = 8;
	localparam int TILE_SIZE = 8;
	localparam int V_START = 8;	// first display line of the map
	localparam int BYTES_PER_TILE_ROW = 4;
	localparam int PATTERN_COUNT = 8;
	localparam int NAME_DEPTH = 256;
	localparam int PATTERN_DEPTH = 256;
	localparam int FETCH_START = 1312;	// hcount where the fetch for the next line begins

	typedef logic [7:0] vram_addr_t;

	typedef enum logic [2:0] {
		REG_POINTER = 3'd0,	// table write pointer
		REG_NAME_DATA = 3'd1,
		REG_PATTERN_DATA = 3'd2,
		REG_BG_RED = 3'd3,
		REG_BG_GREEN = 3'd4,
		REG_BG_BLUE = 3'd5
	} reg_addr_e;

	typedef enum logic [2:0] {
		IDLE, READ_NAME, WAIT_NAME, READ_PATTERN,
		WAIT_PATTERN, LOAD_BYTE, NEXT_TILE, LINE_READY
	} fetch_state_e;

endpackage

// ==== source/vga_timing.sv ====
`timescale 1ns/10ps
// free-running counters, hcount counts clocks so each pixel spans two counts
// sync and blank outputs are decoded combinationally and need a register downstream
module vga_timing import video_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	output hcount_t hcount,
	output vcount_t vcount,
	output logic    hs_raw,
	output logic    vs_raw,
	output logic    blank_raw
);

	logic end_of_line;
	logic end_of_frame;

	assign end_of_line = hcount == H_TOTAL - 1;
	assign end_of_frame = vcount == V_TOTAL - 1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hcount <= '0;
			vcount <= '0;
		end else if (end_of_line) begin
			hcount <= '0;
			vcount <= end_of_frame ? '0 : vcount + 10'd1;	// advance at the line wrap
		end else begin
			hcount <= hcount + 11'd1;
		end
	end

	// sync pulses are active low
	assign hs_raw = !((hcount >= H_ACTIVE + H_FRONT) && (hcount < H_ACTIVE + H_FRONT + H_SYNC));
	assign vs_raw = !((vcount >= V_ACTIVE + V_FRONT) && (vcount < V_ACTIVE + V_FRONT + V_SYNC));
	assign blank_raw = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);	// high in the visible area

	// sync pulses sit inside the blanking interval
	assert property (@(posedge clk) disable iff (reset)
		(!hs_raw || !vs_raw) |-> !blank_raw);

endmodule

// ==== source/video_pkg.sv ====
// VGA 640x480 timing for a 50 MHz clock, so one pixel lasts two clocks
// colour codes 1 to 9 index the table and every other code shows white
package video_pkg;

	localparam int H_ACTIVE = 1280;	// 640 pixels at two clocks each
	localparam int H_FRONT = 32;
	localparam int H_SYNC = 192;
	localparam int H_BACK = 96;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;	// 1600
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;	// 525

	typedef logic [10:0] hcount_t;	// clock count along a line
	typedef logic [9:0] vcount_t;	// line count in a frame
	typedef logic [3:0] color_code_t;
	typedef logic [23:0] rgb_t;	// {red, green, blue}

	localparam rgb_t COLOR_TABLE [16] = '{
		1: 24'hfef104,	// yellow
		2: 24'hfe0e03,	// red
		3: 24'hfeb846,	// orange
		4: 24'h00ecfe,	// cyan
		5: 24'hfdbff9,	// pink
		6: 24'he5dfee,	// off white
		7: 24'h1e26b8,	// dark blue
		8: 24'hffc0b7,	// salmon
		default: 24'hffffff	// 9 is white, and so are the unused codes
	};

endpackage

// ==== source/video_ram.sv ====
`timescale 1ns/10ps
// byte memory with one write port and one registered read port
// read data follows the address by one clock, contents start undefined
module video_ram import tile_pkg::*; #(
	parameter int DEPTH = NAME_DEPTH
) (
	input  logic       clk,
	input  logic       we,
	input  vram_addr_t wa,
	input  vram_addr_t ra,
	input  logic [7:0] din,
	output logic [7:0] dout
);

	logic [7:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) mem[wa] <= din;
		dout <= mem[ra];	// old data on a same-address collision
	end

endmodule

// ==== tile_display.f ====
source/video_pkg.sv
source/tile_pkg.sv
source/vga_timing.sv
source/host_regs.sv
source/video_ram.sv
source/tile_fetch.sv
source/line_shifter.sv
source/color_out.sv
source/tile_display.sv
dv/tile_display_tb.sv
